// File: source/matrix_mod_pkg.sv
package matrix_mod_pkg;

  //////////////////////////////////////////////////
  // Matrix index
  //////////////////////////////////////////////////

  // Width of row and column sizes and positions
  parameter int INDEX_WIDTH = 8;

  // Row or column count or position
  typedef logic [INDEX_WIDTH-1:0] index_t;

  //////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    idle,        // Waiting for start
    wait_first,  // Expecting first element of a row
    wait_next,   // Expecting another element of the row
    reduce,      // Remainder unit running
    emit         // Result goes out on this edge
  } mod_state_t;

endpackage

// File: source/element_index_counter.sv
`timescale 1ns/1ps

module element_index_counter (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   clear,
  input  logic                   step,
  input  matrix_mod_pkg::index_t size_i_in,
  input  matrix_mod_pkg::index_t size_j_in,
  output logic                   last_col,
  output logic                   last_row,
  output logic                   col_zero
);

  // Sizes latched at start of matrix
  matrix_mod_pkg::index_t size_i;
  matrix_mod_pkg::index_t size_j;

  // Current element position
  matrix_mod_pkg::index_t row;
  matrix_mod_pkg::index_t col;

  //////////////////////////////////////////////////
  // Position tracking
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_i <= '0;
      size_j <= '0;
      row    <= '0;
      col    <= '0;
    end else if (clear) begin
      // New matrix takes sizes from ports
      size_i <= size_i_in;
      size_j <= size_j_in;
      row    <= '0;
      col    <= '0;
    end else if (step) begin
      if (last_col) begin
        // Wrap to next row
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // Flags straight from the counters
  assign last_col = (col == size_j - 1'b1);
  assign last_row = (row == size_i - 1'b1);
  assign col_zero = (col == '0);

endmodule

// File: source/modulo_remainder.sv
`timescale 1ns/1ps

module modulo_remainder #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 launch,
  input  logic [DATA_SIZE-1:0] dividend,
  input  logic [DATA_SIZE-1:0] divisor,
  output logic                 done,
  output logic [DATA_SIZE-1:0] remainder
);

  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  // Control
  logic             busy;
  logic             bypass;
  logic [CNT_W-1:0] count;

  // Datapath
  logic [DATA_SIZE-1:0] shift_q;   // dividend bits not yet consumed
  logic [DATA_SIZE-1:0] div_q;
  logic [DATA_SIZE-1:0] rem_q;

  // One restoring step
  logic [DATA_SIZE-1:0] step_r;
  logic                 step_bit;
  logic [DATA_SIZE-1:0] step_d;
  logic [DATA_SIZE:0]   trial;
  logic [DATA_SIZE:0]   diff;
  logic [DATA_SIZE-1:0] next_r;

  //////////////////////////////////////////////////
  // Shift and subtract
  //////////////////////////////////////////////////

  // First step runs on the launch edge itself, from a zero remainder
  assign step_r   = launch ? '0 : rem_q;
  assign step_bit = launch ? dividend[DATA_SIZE-1] : shift_q[DATA_SIZE-1];
  assign step_d   = launch ? divisor : div_q;

  assign trial  = {step_r, step_bit};
  assign diff   = trial - {1'b0, step_d};
  // Keep difference only if it did not go negative
  assign next_r = (trial >= {1'b0, step_d}) ? diff[DATA_SIZE-1:0] : trial[DATA_SIZE-1:0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy   <= 1'b0;
      bypass <= 1'b0;
      count  <= '0;
      done   <= 1'b0;
    end else if (launch) begin
      bypass <= (divisor == '0);
      count  <= CNT_W'(DATA_SIZE - 1);
      busy   <= (DATA_SIZE > 1);
      done   <= (DATA_SIZE == 1);
    end else begin
      done <= 1'b0;
      if (busy) begin
        count <= count - 1'b1;
        // Last bit consumed on this edge
        if (count == CNT_W'(1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (launch) begin
      shift_q <= dividend << 1;
      div_q   <= divisor;
      // Modulus zero hands the element back as is
      rem_q   <= (divisor == '0) ? dividend : next_r;
    end else if (busy) begin
      shift_q <= shift_q << 1;
      if (!bypass) begin
        rem_q <= next_r;
      end
    end
  end

  // Held until next launch
  assign remainder = rem_q;

endmodule

// File: source/matrix_mod_ctrl.sv
`timescale 1ns/1ps

module matrix_mod_ctrl #(
  parameter int DATA_SIZE = 16
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic                 data_in_i_enable,
  input  logic                 data_in_j_enable,
  input  logic [DATA_SIZE-1:0] data_in,
  input  logic [DATA_SIZE-1:0] modulo_in,
  input  logic                 last_col,
  input  logic                 last_row,
  input  logic                 col_zero,
  input  logic                 done,
  input  logic [DATA_SIZE-1:0] remainder,
  output logic                 ready,
  output logic                 data_out_i_enable,
  output logic                 data_out_j_enable,
  output logic [DATA_SIZE-1:0] data_out,
  output logic                 clear,
  output logic                 step,
  output logic                 launch,
  output logic [DATA_SIZE-1:0] dividend,
  output logic [DATA_SIZE-1:0] divisor
);

  matrix_mod_pkg::mod_state_t state;
  matrix_mod_pkg::mod_state_t state_next;

  logic accept_first;
  logic accept_next;
  logic accept;

  //////////////////////////////////////////////////
  // Input acceptance
  //////////////////////////////////////////////////

  // Column zero selects which strobe counts
  assign accept_first = (state == matrix_mod_pkg::wait_first) && col_zero && data_in_i_enable;
  assign accept_next  = (state == matrix_mod_pkg::wait_next) && !col_zero && data_in_j_enable;
  assign accept       = accept_first || accept_next;

  // Counter control
  assign clear = (state == matrix_mod_pkg::idle) && start;
  assign step  = (state == matrix_mod_pkg::emit);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      matrix_mod_pkg::idle: begin
        if (start) state_next = matrix_mod_pkg::wait_first;
      end
      matrix_mod_pkg::wait_first,
      matrix_mod_pkg::wait_next: begin
        if (accept) state_next = matrix_mod_pkg::reduce;
      end
      matrix_mod_pkg::reduce: begin
        if (done) state_next = matrix_mod_pkg::emit;
      end
      matrix_mod_pkg::emit: begin
        // Last element of the matrix ends the run
        if (last_col && last_row) begin
          state_next = matrix_mod_pkg::idle;
        end else if (last_col) begin
          state_next = matrix_mod_pkg::wait_first;
        end else begin
          state_next = matrix_mod_pkg::wait_next;
        end
      end
      default: state_next = matrix_mod_pkg::idle;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= matrix_mod_pkg::idle;
      launch            <= 1'b0;
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      data_out          <= '0;
    end else begin
      state  <= state_next;
      // One cycle after acceptance
      launch <= accept;

      // Output strobes default low
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      if (state == matrix_mod_pkg::emit) begin
        data_out          <= remainder;
        data_out_j_enable <= 1'b1;
        data_out_i_enable <= last_col;
        ready             <= last_col && last_row;
      end
    end
  end

  // Operands for the remainder unit
  always_ff @(posedge CLK) begin
    if (accept) begin
      dividend <= data_in;
      divisor  <= modulo_in;
    end
  end

endmodule

// File: source/matrix_mod.sv
`timescale 1ns/1ps

module matrix_mod #(
  parameter int DATA_SIZE = 16
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  input  logic                   data_in_i_enable,
  input  logic                   data_in_j_enable,
  input  logic [DATA_SIZE-1:0]   modulo_in,
  input  matrix_mod_pkg::index_t size_i_in,
  input  matrix_mod_pkg::index_t size_j_in,
  input  logic [DATA_SIZE-1:0]   data_in,
  output logic                   ready,
  output logic                   data_out_i_enable,
  output logic                   data_out_j_enable,
  output logic [DATA_SIZE-1:0]   data_out
);

  // Controller to counter
  logic clear;
  logic step;
  logic last_col;
  logic last_row;
  logic col_zero;

  // Controller to remainder unit
  logic                 launch;
  logic                 done;
  logic [DATA_SIZE-1:0] dividend;
  logic [DATA_SIZE-1:0] divisor;
  logic [DATA_SIZE-1:0] remainder;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  matrix_mod_ctrl #(
    .DATA_SIZE(DATA_SIZE)
  ) ctrl_inst (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .data_in          (data_in),
    .modulo_in        (modulo_in),
    .last_col         (last_col),
    .last_row         (last_row),
    .col_zero         (col_zero),
    .done             (done),
    .remainder        (remainder),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out),
    .clear            (clear),
    .step             (step),
    .launch           (launch),
    .dividend         (dividend),
    .divisor          (divisor)
  );

  // Row and column tracking
  element_index_counter index_inst (
    .CLK      (CLK),
    .RST      (RST),
    .clear    (clear),
    .step     (step),
    .size_i_in(size_i_in),
    .size_j_in(size_j_in),
    .last_col (last_col),
    .last_row (last_row),
    .col_zero (col_zero)
  );

  modulo_remainder #(
    .DATA_SIZE(DATA_SIZE)
  ) remainder_inst (
    .CLK      (CLK),
    .RST      (RST),
    .launch   (launch),
    .dividend (dividend),
    .divisor  (divisor),
    .done     (done),
    .remainder(remainder)
  );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  // 4 ns period
  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Reset held for 3 rising edges
  initial begin
    RST = 1'b1;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

// File: verif/matrix_mod_checker.sv
`timescale 1ns/1ps

module matrix_mod_checker (
  input logic                       CLK,
  input logic                       RST,
  input matrix_mod_pkg::mod_state_t state,
  input logic                       launch,
  input logic                       ready,
  input logic                       data_out_i_enable,
  input logic                       data_out_j_enable
);

  //////////////////////////////////////////////////
  // Launch
  //////////////////////////////////////////////////

  // Only as the FSM moves from a waiting state into reduce
  launch_after_accept: assert property (@(posedge CLK) disable iff (RST)
    launch |-> (state == matrix_mod_pkg::reduce) &&
      ($past(state) == matrix_mod_pkg::wait_first ||
       $past(state) == matrix_mod_pkg::wait_next))
    else $error("launch raised outside an accepted element");

  //////////////////////////////////////////////////
  // Output strobes
  //////////////////////////////////////////////////

  j_enable_single: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |=> !data_out_j_enable)
    else $error("data_out_j_enable held longer than one cycle");

  i_enable_single: assert property (@(posedge CLK) disable iff (RST)
    data_out_i_enable |=> !data_out_i_enable)
    else $error("data_out_i_enable held longer than one cycle");

  ready_single: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("ready held longer than one cycle");

  // End of row and end of matrix ride on an element result
  ready_with_j: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_j_enable)
    else $error("ready without data_out_j_enable");

  i_with_j: assert property (@(posedge CLK) disable iff (RST)
    data_out_i_enable |-> data_out_j_enable)
    else $error("data_out_i_enable without data_out_j_enable");

endmodule

bind matrix_mod_ctrl matrix_mod_checker checker_inst (
  .CLK              (CLK),
  .RST              (RST),
  .state            (state),
  .launch           (launch),
  .ready            (ready),
  .data_out_i_enable(data_out_i_enable),
  .data_out_j_enable(data_out_j_enable)
);

// File: verif/matrix_mod_tb.sv
`timescale 1ns/1ps

module matrix_mod_tb;

  localparam int DATA_SIZE = 16;
  // Negedges from a strobe seen on the inputs to its result seen on the outputs
  localparam int LATENCY = DATA_SIZE + 3;

  logic                   CLK;
  logic                   RST;
  logic                   start;
  logic                   data_in_i_enable;
  logic                   data_in_j_enable;
  logic [DATA_SIZE-1:0]   modulo_in;
  matrix_mod_pkg::index_t size_i_in;
  matrix_mod_pkg::index_t size_j_in;
  logic [DATA_SIZE-1:0]   data_in;
  logic                   ready;
  logic                   data_out_i_enable;
  logic                   data_out_j_enable;
  logic [DATA_SIZE-1:0]   data_out;

  // Tags travelling with an element strobe
  logic                 real_strobe;
  logic [DATA_SIZE-1:0] strobe_expect;
  logic                 strobe_row_end;
  logic                 strobe_last;

  // Golden data
  int mod_q[$];
  int rows_q[$];
  int cols_q[$];
  int elem_q[$];
  int result_q[$];

  // Pending results
  int due_q[$];
  int value_q[$];
  int row_end_q[$];
  int last_q[$];
  int count_q[$];
  int row_count_q[$];

  int errors = 0;
  int total_elems = 0;
  int matrix_total = 0;
  int matrices_done = 0;
  int outs_seen = 0;
  int rows_seen = 0;
  int edge_no = 0;
  int cycles = 0;
  int cycle_limit = 0;

  tb_clock_gen clock_inst (
    .CLK(CLK),
    .RST(RST)
  );

  matrix_mod #(
    .DATA_SIZE(DATA_SIZE)
  ) matrix_mod_inst (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .modulo_in        (modulo_in),
    .size_i_in        (size_i_in),
    .size_j_in        (size_j_in),
    .data_in          (data_in),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string name);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic load_golden();
    int    fd;
    int    code;
    int    m;
    int    r;
    int    c;
    int    e;
    int    x;
    string tok;
    string rest;
    fd = $fopen("verif/matrix_mod_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file verif/matrix_mod_golden.txt");
      $display("Result: FAILED");
      $finish;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          // Rest of a comment line
          code = $fgets(rest, fd);
        end else if (tok == "M") begin
          code = $fscanf(fd, "%h %h %h", m, r, c);
          mod_q.push_back(m);
          rows_q.push_back(r);
          cols_q.push_back(c);
          repeat (r * c) begin
            code = $fscanf(fd, "%h %h", e, x);
            elem_q.push_back(e);
            result_q.push_back(x);
          end
          total_elems += r * c;
          matrix_total++;
        end
      end
      $fclose(fd);
    end
  endtask

  // One rising edge of input drive with start dropped
  task automatic drive_inputs(input logic i_en, input logic j_en,
                              input logic [DATA_SIZE-1:0] value, input logic tag);
    @(posedge CLK);
    start            <= 1'b0;
    data_in_i_enable <= i_en;
    data_in_j_enable <= j_en;
    data_in          <= value;
    real_strobe      <= tag;
  endtask

  task automatic send_element(input int value, input int expect_val, input bit first,
                              input bit row_end, input bit last);
    int gap;
    int hold;
    gap = $urandom_range(3, 0);
    repeat (gap) drive_inputs(1'b0, 1'b0, '0, 1'b0);
    // Wrong strobe for this position
    if ($urandom_range(1, 0) == 1) begin
      drive_inputs(!first, first, DATA_SIZE'($urandom), 1'b0);
    end
    drive_inputs(first, !first, DATA_SIZE'(value), 1'b1);
    strobe_expect  <= DATA_SIZE'(expect_val);
    strobe_row_end <= row_end;
    strobe_last    <= last;
    // Stray strobes while the reduction runs
    hold = $urandom_range(DATA_SIZE, 1);
    repeat (hold) drive_inputs(1'b0, 1'b0, '0, 1'b0);
    drive_inputs(1'b1, 1'b1, DATA_SIZE'($urandom), 1'b0);
    drive_inputs(1'b0, 1'b0, '0, 1'b0);
    do @(negedge CLK); while (!data_out_j_enable);
  endtask

  task automatic run_matrix(input int modulus, input int rows, input int cols);
    @(posedge CLK);
    start     <= 1'b1;
    modulo_in <= DATA_SIZE'(modulus);
    size_i_in <= matrix_mod_pkg::index_t'(rows);
    size_j_in <= matrix_mod_pkg::index_t'(cols);
    count_q.push_back(rows * cols);
    row_count_q.push_back(rows);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        send_element(elem_q.pop_front(), result_q.pop_front(), c == 0, c == cols - 1,
                     (r == rows - 1) && (c == cols - 1));
      end
    end
  endtask

  task automatic check_output();
    if (due_q.size() == 0) begin
      errors++;
      $display("[ERROR] %0t ns: output pulse with no element pending", $time);
    end else begin
      check_value(edge_no, due_q.pop_front(), "latency");
      check_value(data_out, value_q.pop_front(), "data_out");
      check_value(data_out_i_enable, row_end_q.pop_front(), "data_out_i_enable");
      check_value(ready, last_q.pop_front(), "ready");
    end
    outs_seen++;
    if (data_out_i_enable) rows_seen++;
    if (ready) begin
      if (count_q.size() == 0) begin
        errors++;
        $display("[ERROR] %0t ns: ready with no matrix pending", $time);
      end else begin
        check_value(outs_seen, count_q.pop_front(), "outputs per matrix");
        check_value(rows_seen, row_count_q.pop_front(), "rows per matrix");
      end
      outs_seen = 0;
      rows_seen = 0;
      matrices_done++;
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and watchdog
  //////////////////////////////////////////////////

  // Sampled mid-cycle, away from the driving edge
  always @(negedge CLK) begin
    if (!RST) begin
      edge_no = edge_no + 1;
      if (real_strobe) begin
        due_q.push_back(edge_no + LATENCY);
        value_q.push_back(strobe_expect);
        row_end_q.push_back(strobe_row_end);
        last_q.push_back(strobe_last);
      end
      if (data_out_j_enable) check_output();
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the design stopped responding after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int seed_val;
    start            = 1'b0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    modulo_in        = '0;
    size_i_in        = '0;
    size_j_in        = '0;
    data_in          = '0;
    real_strobe      = 1'b0;
    strobe_expect    = '0;
    strobe_row_end   = 1'b0;
    strobe_last      = 1'b0;
    seed_val = $urandom(32'h3e9533bc);
    load_golden();
    check_value(matrix_total > 0, 1, "golden matrices");
    cycle_limit = total_elems * (DATA_SIZE + 8) + 200;
    @(negedge RST);
    while (mod_q.size() > 0) begin
      run_matrix(mod_q.pop_front(), rows_q.pop_front(), cols_q.pop_front());
    end
    repeat (4) @(negedge CLK);
    check_value(due_q.size(), 0, "pending results");
    check_value(matrices_done, matrix_total, "matrices finished");
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: verif/matrix_mod_golden.txt
# Each matrix opens with M then modulus, rows and cols
# Then element and expected remainder pairs in hex, row-major
M 0007 2 3
0064 0002  0005 0005  00ff 0003
1234 0005  ffff 0001  0007 0000
M 0000 1 1
abcd abcd
M 000a 1 4
0009 0009  0017 0003  03e7 0009  2711 0001
M 0100 3 1
1234 0034
00ff 00ff
ffff 00ff
M 8000 2 2
8001 0001  7fff 7fff
ffff 7fff  8000 0000
M 0001 1 1
5a5a 0000
M 0003 2 2
000b 0002  0064 0001
0002 0002  0bb8 0000
M 0000 2 2
0000 0000  1111 1111
0001 0001  fffe fffe
M fffb 1 2
ffff 0004  0010 0010

// File: all.f
source/matrix_mod_pkg.sv
source/element_index_counter.sv
source/modulo_remainder.sv
source/matrix_mod_ctrl.sv
source/matrix_mod.sv
verif/tb_clock_gen.sv
verif/matrix_mod_checker.sv
verif/matrix_mod_tb.sv

// File: Bender.yml
package:
  name: matrix_mod

sources:
  - files:
      - source/matrix_mod_pkg.sv
      - source/element_index_counter.sv
      - source/modulo_remainder.sv
      - source/matrix_mod_ctrl.sv
      - source/matrix_mod.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/matrix_mod_checker.sv
      - verif/matrix_mod_tb.sv
